//--- clkPkg.sv
`default_nettype none

package clkPkg;

  // Diagnostic bus geometry
  localparam int diagAdrWidth  = 5;
  localparam int diagDataWidth = 6;
  // Address splits into a group code over a function select
  localparam int grpWidth      = 2;
  localparam int selWidth      = 3;

  // Clock control datapath widths
  localparam int burstWidth  = 8;
  localparam int nibbleWidth = 4;
  localparam int rateWidth   = 2;
  localparam int timeWidth   = 2;
  // Divider spans the slowest rate, 2**3 cycles
  localparam int divWidth    = 2 ** rateWidth - 1;

  // Address group codes
  localparam logic [grpWidth-1:0] grpCtl  = 2'd0;
  localparam logic [grpWidth-1:0] grpLoad = 2'd1;
  localparam logic [grpWidth-1:0] grpRead = 2'd2;

  // Control function selects, old codes 3 and 4 are gone
  localparam logic [selWidth-1:0] fnStop       = 3'd0;
  localparam logic [selWidth-1:0] fnStart      = 3'd1;
  localparam logic [selWidth-1:0] fnSingleStep = 3'd2;
  localparam logic [selWidth-1:0] fnBurst      = 3'd5;
  localparam logic [selWidth-1:0] fnSetReset   = 3'd6;
  localparam logic [selWidth-1:0] fnClrReset   = 3'd7;

  // Load selects, same numbering as old 042 to 045
  localparam logic [selWidth-1:0] ldBurstLo = 3'd2;
  localparam logic [selWidth-1:0] ldBurstHi = 3'd3;
  localparam logic [selWidth-1:0] ldRate    = 3'd4;
  localparam logic [selWidth-1:0] ldDisable = 3'd5;

  // Readback selects
  localparam logic [selWidth-1:0] rdBurstHi  = 3'd0;
  localparam logic [selWidth-1:0] rdBurstLo  = 3'd1;
  localparam logic [selWidth-1:0] rdRunState = 3'd2;
  localparam logic [selWidth-1:0] rdConfig   = 3'd3;

  // Wishbone classic request from the diagnostic master
  typedef struct packed {
    logic                     cyc;
    logic                     stb;
    logic                     we;
    logic [diagAdrWidth-1:0]  adr;
    logic [diagDataWidth-1:0] dat;
  } wbReqT;

  // Wishbone classic response
  typedef struct packed {
    logic                     ack;
    logic [diagDataWidth-1:0] dat;
  } wbRspT;

  // One-cycle command strobes out of the diagnostic port
  typedef struct packed {
    logic                     ctlWrite;
    logic [selWidth-1:0]      ctlCode;
    logic                     load;
    logic [selWidth-1:0]      loadSel;
    logic [diagDataWidth-1:0] loadData;
  } diagCmdT;

  // EBOX group disables
  typedef struct packed {
    logic crm;
    logic edp;
    logic ctl;
  } groupDisT;

  // EBOX group clock enables, one MBOX cycle wide
  typedef struct packed {
    logic crm;
    logic edp;
    logic ctl;
  } clkEnT;

  // Values after CLK
  localparam logic [rateWidth-1:0]  rateReset   = '0;
  localparam logic [burstWidth-1:0] burstReset  = '0;
  localparam groupDisT              disReset    = '0;
  localparam logic                  mrResetInit = 1'b1;

endpackage

`default_nettype wire

//--- diagPort.sv
`timescale 1ns/100ps
`default_nettype none

module diagPort (
  input  logic                           MBOX_CLK,
  input  logic                           CLK,
  input  clkPkg::wbReqT                  wbReq,
  output clkPkg::wbRspT                  wbRsp,
  output clkPkg::diagCmdT                cmd,
  input  logic [clkPkg::burstWidth-1:0]  burstCount,
  input  logic                           go,
  input  logic                           burstMode,
  input  logic                           stepPending,
  input  logic                           mrReset,
  input  logic [clkPkg::rateWidth-1:0]   rateSel,
  input  clkPkg::groupDisT               groupDis
);
  import clkPkg::*;

  logic                     ackQ;
  logic [diagDataWidth-1:0] datQ;
  logic                     newReq;
  logic [grpWidth-1:0]      grp;
  logic [selWidth-1:0]      sel;
  logic [diagDataWidth-1:0] rdWord;

  // A request is new until our ack has been seen
  assign newReq = wbReq.cyc & wbReq.stb & ~ackQ;

  // Group sits above the function select
  assign grp = wbReq.adr[diagAdrWidth-1 -: grpWidth];
  assign sel = wbReq.adr[selWidth-1:0];

  // Strobes live in the cycle that ends with the ack edge
  // so every write lands on the same edge that raises ack
  always_comb begin
    cmd.ctlWrite = newReq & wbReq.we & (grp == grpCtl);
    cmd.ctlCode  = sel;
    cmd.load     = newReq & wbReq.we & (grp == grpLoad);
    cmd.loadSel  = sel;
    cmd.loadData = wbReq.dat;
  end

  // Readback word mux
  always_comb begin
    rdWord = '0;
    if (grp == grpRead) begin
      case (sel)
        rdBurstHi: begin
          rdWord = {{(diagDataWidth-nibbleWidth){1'b0}},
                    burstCount[burstWidth-1 -: nibbleWidth]};
        end
        rdBurstLo: begin
          rdWord = {{(diagDataWidth-nibbleWidth){1'b0}},
                    burstCount[nibbleWidth-1:0]};
        end
        // Run state packs the mode bits over the rate
        rdRunState: rdWord = {go, burstMode, mrReset, stepPending, rateSel};
        rdConfig:   rdWord = {groupDis.crm, groupDis.edp, groupDis.ctl, 3'b000};
        default:    rdWord = '0;
      endcase
    end
  end

  // Ack and read data register together
  always_ff @(posedge MBOX_CLK or posedge CLK) begin
    if (CLK) begin
      ackQ <= 1'b0;
      datQ <= '0;
    end else begin
      ackQ <= newReq;
      // Data bus is zero outside a read ack
      datQ <= (newReq & ~wbReq.we) ? rdWord : '0;
    end
  end

  assign wbRsp.ack = ackQ;
  assign wbRsp.dat = datQ;

  // Master still holds stb in the ack cycle yet gets one ack only
  ackSingle: assert property (@(posedge MBOX_CLK) disable iff (CLK)
    ackQ |=> !ackQ)
    else $error("diagPort raised ack in two cycles in a row");

endmodule

`default_nettype wire

//--- clockControlRegs.sv
`timescale 1ns/100ps
`default_nettype none

module clockControlRegs (
  input  logic                          MBOX_CLK,
  input  logic                          CLK,
  input  clkPkg::diagCmdT               cmd,
  output logic [clkPkg::rateWidth-1:0]  rateSel,
  output clkPkg::groupDisT              groupDis,
  output logic                          mrReset
);
  import clkPkg::*;

  logic rateHit;
  logic disHit;
  logic setRst;
  logic clrRst;

  // Load function decode
  assign rateHit = cmd.load & (cmd.loadSel == ldRate);
  assign disHit  = cmd.load & (cmd.loadSel == ldDisable);

  // Machine reset set and release
  assign setRst = cmd.ctlWrite & (cmd.ctlCode == fnSetReset);
  assign clrRst = cmd.ctlWrite & (cmd.ctlCode == fnClrReset);

  always_ff @(posedge MBOX_CLK or posedge CLK) begin
    if (CLK) begin
      rateSel  <= rateReset;
      groupDis <= disReset;
      // Machine comes up held in reset
      mrReset  <= mrResetInit;
    end else begin
      if (rateHit) begin
        rateSel <= cmd.loadData[rateWidth-1:0];
      end
      // Data bits 2..0 map to crm, edp, ctl
      if (disHit) begin
        groupDis.crm <= cmd.loadData[2];
        groupDis.edp <= cmd.loadData[1];
        groupDis.ctl <= cmd.loadData[0];
      end
      if (setRst) begin
        mrReset <= 1'b1;
      end else if (clrRst) begin
        mrReset <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

//--- burstCounter.sv
`timescale 1ns/100ps
`default_nettype none

module burstCounter (
  input  logic                           MBOX_CLK,
  input  logic                           CLK,
  input  clkPkg::diagCmdT                cmd,
  input  logic                           stepTaken,
  input  logic                           burstMode,
  output logic [clkPkg::burstWidth-1:0]  burstCount
);
  import clkPkg::*;

  logic loadLo;
  logic loadHi;
  logic countDown;

  // Nibble loads from the low data bits
  assign loadLo = cmd.load & (cmd.loadSel == ldBurstLo);
  assign loadHi = cmd.load & (cmd.loadSel == ldBurstHi);

  // One count per step the EBOX actually took
  assign countDown = stepTaken & burstMode & (burstCount != '0);

  always_ff @(posedge MBOX_CLK or posedge CLK) begin
    if (CLK) begin
      burstCount <= burstReset;
    end else if (loadLo) begin
      burstCount[nibbleWidth-1:0] <= cmd.loadData[nibbleWidth-1:0];
    end else if (loadHi) begin
      burstCount[burstWidth-1 -: nibbleWidth] <= cmd.loadData[nibbleWidth-1:0];
    end else if (countDown) begin
      burstCount <= burstCount - 1'b1;
    end
  end

  // Zero holds until a nibble is loaded and never wraps to all ones
  noWrap: assert property (@(posedge MBOX_CLK) disable iff (CLK)
    (burstCount == '0) && !loadLo && !loadHi |=> burstCount == '0)
    else $error("burst count left zero without a load");

endmodule

`default_nettype wire

//--- clockGate.sv
`timescale 1ns/100ps
`default_nettype none

module clockGate (
  input  logic                           MBOX_CLK,
  input  logic                           CLK,
  input  clkPkg::diagCmdT                cmd,
  input  logic [clkPkg::rateWidth-1:0]   rateSel,
  input  logic [clkPkg::burstWidth-1:0]  burstCount,
  input  logic                           stepTaken,
  output logic                           stepReq,
  output logic                           go,
  output logic                           burstMode,
  output logic                           stepPending
);
  import clkPkg::*;

  logic [divWidth-1:0] divCnt;
  logic [divWidth-1:0] divMask;
  logic                rateTick;
  logic                stopWrite;
  logic                stepWant;

  // Low rateSel bits of the divider must be zero for a tick
  assign divMask  = ~({divWidth{1'b1}} << rateSel);
  assign rateTick = (divCnt & divMask) == '0;

  assign stopWrite = cmd.ctlWrite & (cmd.ctlCode == fnStop);

  // Something wants a step, a stop cancels one rising on its own edge
  assign stepWant = ~stopWrite &
                    (go | (burstMode & (burstCount != '0)) | stepPending);

  // Free-running rate divider
  always_ff @(posedge MBOX_CLK or posedge CLK) begin
    if (CLK) begin
      divCnt <= '0;
    end else begin
      divCnt <= divCnt + 1'b1;
    end
  end

  // Run state
  always_ff @(posedge MBOX_CLK or posedge CLK) begin
    if (CLK) begin
      go          <= 1'b0;
      burstMode   <= 1'b0;
      stepPending <= 1'b0;
    end else begin
      if (stepTaken) begin
        stepPending <= 1'b0;
      end
      // Any other code, reset ones included, acts as a stop
      if (cmd.ctlWrite) begin
        go        <= (cmd.ctlCode == fnStart);
        burstMode <= (cmd.ctlCode == fnBurst);
        if (cmd.ctlCode == fnSingleStep) begin
          stepPending <= 1'b1;
        end
      end
    end
  end

  // Request holds until eboxSync takes it
  always_ff @(posedge MBOX_CLK or posedge CLK) begin
    if (CLK) begin
      stepReq <= 1'b0;
    end else if (stepTaken) begin
      stepReq <= 1'b0;
    end else if (!stepReq && rateTick && stepWant) begin
      stepReq <= 1'b1;
    end
  end

  reqHold: assert property (@(posedge MBOX_CLK) disable iff (CLK)
    stepReq && !stepTaken |=> stepReq)
    else $error("step request dropped before it was taken");

endmodule

`default_nettype wire

//--- eboxSync.sv
`timescale 1ns/100ps
`default_nettype none

module eboxSync (
  input  logic                          MBOX_CLK,
  input  logic                          CLK,
  input  logic                          stepReq,
  input  logic [clkPkg::timeWidth-1:0]  cramTime,
  input  logic                          mboxWait,
  input  logic                          mrReset,
  input  clkPkg::groupDisT              groupDis,
  output logic                          stepTaken,
  output logic                          eboxSync,
  output clkPkg::clkEnT                 clkEn
);
  import clkPkg::*;

  logic [timeWidth-1:0] phase;
  logic                 phaseDone;
  logic                 syncEn;

  // Phase has run at least as long as the microcode time field asks
  assign phaseDone = phase >= cramTime;

  // Sync point, held off by MBOX wait and machine reset
  // and blocked while the previous step is still in flight
  assign syncEn = stepReq & phaseDone & ~mboxWait & ~mrReset &
                  ~eboxSync & ~stepTaken;

  // MBOX phase counter restarts with each EBOX clock
  always_ff @(posedge MBOX_CLK or posedge CLK) begin
    if (CLK) begin
      phase <= '0;
    end else if (eboxSync) begin
      phase <= '0;
    end else if (phase != '1) begin
      phase <= phase + 1'b1;
    end
  end

  // Sync flip-flop and then the enables one MBOX cycle later
  always_ff @(posedge MBOX_CLK or posedge CLK) begin
    if (CLK) begin
      eboxSync  <= 1'b0;
      stepTaken <= 1'b0;
      clkEn     <= '0;
    end else begin
      eboxSync  <= syncEn;
      stepTaken <= eboxSync;
      // Disabled groups miss the pulse but the step still counts
      clkEn.crm <= eboxSync & ~groupDis.crm;
      clkEn.edp <= eboxSync & ~groupDis.edp;
      clkEn.ctl <= eboxSync & ~groupDis.ctl;
    end
  end

  // Every EBOX clock sits right behind a sync pulse
  enAfterSync: assert property (@(posedge MBOX_CLK) disable iff (CLK)
    (clkEn.crm | clkEn.edp | clkEn.ctl) |-> $past(eboxSync))
    else $error("EBOX clock enable without a sync pulse before it");

endmodule

`default_nettype wire

//--- klClock.sv
`timescale 1ns/100ps
`default_nettype none

module klClock (
  input  logic                          MBOX_CLK,
  input  logic                          CLK,
  input  clkPkg::wbReqT                 wbReq,
  output clkPkg::wbRspT                 wbRsp,
  input  logic [clkPkg::timeWidth-1:0]  cramTime,
  input  logic                          mboxWait,
  output logic                          eboxSync,
  output clkPkg::clkEnT                 clkEn,
  output logic                          mrReset
);
  import clkPkg::*;

  diagCmdT               cmd;
  groupDisT              groupDis;
  logic [rateWidth-1:0]  rateSel;
  logic [burstWidth-1:0] burstCount;
  logic                  go;
  logic                  burstMode;
  logic                  stepPending;
  logic                  stepReq;
  logic                  stepTaken;

  // Diagnostic bus slave and readback
  diagPort uDiag (
    .MBOX_CLK    (MBOX_CLK),
    .CLK         (CLK),
    .wbReq       (wbReq),
    .wbRsp       (wbRsp),
    .cmd         (cmd),
    .burstCount  (burstCount),
    .go          (go),
    .burstMode   (burstMode),
    .stepPending (stepPending),
    .mrReset     (mrReset),
    .rateSel     (rateSel),
    .groupDis    (groupDis)
  );

  // Rate, disables and machine reset
  clockControlRegs uRegs (
    .MBOX_CLK (MBOX_CLK),
    .CLK      (CLK),
    .cmd      (cmd),
    .rateSel  (rateSel),
    .groupDis (groupDis),
    .mrReset  (mrReset)
  );

  burstCounter uBurst (
    .MBOX_CLK   (MBOX_CLK),
    .CLK        (CLK),
    .cmd        (cmd),
    .stepTaken  (stepTaken),
    .burstMode  (burstMode),
    .burstCount (burstCount)
  );

  // Run state and paced step requests
  clockGate uGate (
    .MBOX_CLK    (MBOX_CLK),
    .CLK         (CLK),
    .cmd         (cmd),
    .rateSel     (rateSel),
    .burstCount  (burstCount),
    .stepTaken   (stepTaken),
    .stepReq     (stepReq),
    .go          (go),
    .burstMode   (burstMode),
    .stepPending (stepPending)
  );

  // MBOX sync point and EBOX group enables
  eboxSync uSync (
    .MBOX_CLK  (MBOX_CLK),
    .CLK       (CLK),
    .stepReq   (stepReq),
    .cramTime  (cramTime),
    .mboxWait  (mboxWait),
    .mrReset   (mrReset),
    .groupDis  (groupDis),
    .stepTaken (stepTaken),
    .eboxSync  (eboxSync),
    .clkEn     (clkEn)
  );

endmodule

`default_nettype wire

//--- klClockTb.sv
`timescale 1ns/100ps
`default_nettype none

module klClockTb;
  import clkPkg::*;

  // Quiet time after a run that lets a leftover step land
  localparam int idleWait = 32;

  logic                 MBOX_CLK;
  logic                 CLK;
  wbReqT                wbReq;
  wbRspT                wbRsp;
  logic [timeWidth-1:0] cramTime;
  logic                 mboxWait;
  logic                 eboxSync;
  clkEnT                clkEn;
  logic                 mrReset;

  // Enables as a vector with crm in bit 2 down to ctl in bit 0
  logic [2:0]           enVec;
  logic [2:0]           disMask;
  logic [rateWidth-1:0] rateModel;
  logic [31:0]          seed;
  logic                 gapCheck;
  int                   cycleCnt;
  int                   cycleLimit;
  int                   pulseCnt;
  int                   grpCnt [3];
  int                   lastPulse;

  klClock uut (
    .MBOX_CLK (MBOX_CLK),
    .CLK      (CLK),
    .wbReq    (wbReq),
    .wbRsp    (wbRsp),
    .cramTime (cramTime),
    .mboxWait (mboxWait),
    .eboxSync (eboxSync),
    .clkEn    (clkEn),
    .mrReset  (mrReset)
  );

  assign enVec = clkEn;

  initial begin
    MBOX_CLK = 1'b0;
    forever #4 MBOX_CLK = ~MBOX_CLK;
  end

  task automatic failRun(input string why);
    $display("%s", why);
    $display("*** FAILED ***");
    $fatal(1, "Simulation stopped on first error");
  endtask

  task automatic expectEq(input string name, input logic [31:0] exp, input logic [31:0] got);
    if (exp !== got) begin
      failRun($sformatf("MISMATCH %s expected 0x%0h got 0x%0h", name, exp, got));
    end
  endtask

  function automatic logic [31:0] randWord();
    logic [31:0] s;
    s = seed;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    seed = s;
    return s;
  endfunction

  // Cycles a test may take per pulse and for bus traffic
  function automatic int testLength(input int pulses, input int ct, input int extra);
    return pulses * 8 * (ct + 2) + 50 + extra;
  endfunction

  // Shortest legal spacing between two EBOX clocks
  function automatic int minGap(input logic [1:0] r, input logic [1:0] t);
    int a;
    int b;
    a = 1 << r;
    b = t + 1;
    return (a > b) ? a : b;
  endfunction

  // Run state word as laid out on the diagnostic bus
  function automatic logic [5:0] runWord(input logic g, input logic b, input logic m,
                                         input logic s, input logic [1:0] r);
    return {g, b, m, s, r};
  endfunction

  // One classic cycle with stb held until ack and dropped on the next edge
  task automatic busCycle(input logic we, input logic [1:0] grp, input logic [2:0] sel,
                          input logic [5:0] wdat, output logic [5:0] rdat);
    wbReqT req;
    req.cyc = 1'b1;
    req.stb = 1'b1;
    req.we  = we;
    req.adr = {grp, sel};
    req.dat = wdat;
    @(posedge MBOX_CLK);
    wbReq <= req;
    @(negedge MBOX_CLK);
    while (!wbRsp.ack) @(negedge MBOX_CLK);
    rdat = wbRsp.dat;
    @(posedge MBOX_CLK);
    wbReq <= '0;
  endtask

  task automatic writeFn(input logic [2:0] code);
    logic [5:0] unused;
    busCycle(1'b1, grpCtl, code, 6'h00, unused);
  endtask

  task automatic loadReg(input logic [2:0] sel, input logic [5:0] dat);
    logic [5:0] unused;
    busCycle(1'b1, grpLoad, sel, dat, unused);
  endtask

  task automatic readExpect(input logic [1:0] grp, input logic [2:0] sel,
                            input string name, input logic [5:0] exp);
    logic [5:0] got;
    busCycle(1'b0, grp, sel, 6'h00, got);
    expectEq(name, exp, got);
  endtask

  task automatic waitPulses(input int target);
    while (pulseCnt < target) @(posedge MBOX_CLK);
  endtask

  task automatic idleCycles(input int n);
    repeat (n) @(posedge MBOX_CLK);
  endtask

  // Run length guard
  always @(posedge MBOX_CLK) begin
    cycleCnt <= cycleCnt + 1;
    if (cycleCnt >= cycleLimit) begin
      failRun($sformatf("Timeout, run did not finish within %0d cycles", cycleLimit));
    end
  end

  // Pulse counter and spacing check
  always @(posedge MBOX_CLK) begin
    if (!CLK && enVec != 3'b000) begin
      if (gapCheck && (cycleCnt - lastPulse) < minGap(rateModel, cramTime)) begin
        failRun($sformatf("EBOX clocks only %0d cycles apart", cycleCnt - lastPulse));
      end
      pulseCnt  <= pulseCnt + 1;
      lastPulse <= cycleCnt;
      for (int i = 0; i < 3; i++) begin
        if (enVec[i]) grpCnt[i] <= grpCnt[i] + 1;
      end
    end
  end

  ackOnce: assert property (@(posedge MBOX_CLK) disable iff (CLK)
    wbRsp.ack |=> !wbRsp.ack)
    else failRun("Wishbone ack stayed high for more than one cycle");

  ackAnswers: assert property (@(posedge MBOX_CLK) disable iff (CLK)
    wbRsp.ack |-> $past(wbReq.cyc && wbReq.stb))
    else failRun("Wishbone ack without a request");

  // Read data bus idles at zero
  datIdle: assert property (@(posedge MBOX_CLK) disable iff (CLK)
    !wbRsp.ack |-> wbRsp.dat == '0)
    else failRun("Read data nonzero outside an ack");

  enAfterSync: assert property (@(posedge MBOX_CLK) disable iff (CLK)
    enVec != 3'b000 |-> $past(eboxSync))
    else failRun("EBOX clock enable without eboxSync in the cycle before");

  // Every enabled group clocks right after the sync point
  syncGivesEn: assert property (@(posedge MBOX_CLK) disable iff (CLK)
    eboxSync |=> enVec == ~disMask)
    else failRun("Enabled groups did not all pulse after eboxSync");

  disabledQuiet: assert property (@(posedge MBOX_CLK) disable iff (CLK)
    (enVec & disMask) == 3'b000)
    else failRun("A disabled EBOX group was clocked");

  waitStalls: assert property (@(posedge MBOX_CLK) disable iff (CLK)
    $past(mboxWait, 2) |-> enVec == 3'b000)
    else failRun("EBOX clock pulsed while the MBOX was waiting");

  resetStalls: assert property (@(posedge MBOX_CLK) disable iff (CLK)
    $past(mrReset, 2) |-> enVec == 3'b000)
    else failRun("EBOX clock pulsed while machine reset was held");

  initial begin
    int         base;
    int         snap;
    int         n3;
    int         n5;
    int         stall5;
    logic [1:0] ct3;
    logic [1:0] ct4;
    logic [1:0] ct5;
    logic [1:0] rate4;
    logic [2:0] mask5;
    logic [31:0] r;
    CLK       = 1'b1;
    wbReq     = '0;
    cramTime  = '0;
    mboxWait  = 1'b0;
    disMask   = 3'b000;
    rateModel = '0;
    gapCheck  = 1'b0;
    seed      = 32'hae15_210e;
    cycleCnt  = 0;
    pulseCnt  = 0;
    lastPulse = -1000;
    for (int i = 0; i < 3; i++) grpCnt[i] = 0;
    // Later test parameters fixed up front so the limit can use them
    n3     = 1 + randWord() % 12;
    ct3    = randWord() % 4;
    ct4    = randWord() % 4;
    rate4  = randWord() % 4;
    n5     = 3 + randWord() % 10;
    ct5    = randWord() % 4;
    mask5  = randWord() % 7;
    stall5 = 4 + randWord() % 30;
    cycleLimit = 2 * (testLength(1, 0, 16 + 40 + idleWait) + testLength(0, 0, 150) +
                      testLength(n3, ct3, 2 * idleWait) + testLength(7, ct4, 2 * idleWait) +
                      testLength(n5, ct5, idleWait + stall5));

    // Start is held off by machine reset
    repeat (16) @(posedge MBOX_CLK);
    CLK <= 1'b0;
    writeFn(fnStart);
    idleCycles(40);
    expectEq("pulseCnt", 0, pulseCnt);
    expectEq("mrReset", 1, mrReset);
    readExpect(grpRead, rdRunState, "rdRunState", runWord(1, 0, 1, 0, 2'd0));
    writeFn(fnStop);
    readExpect(grpRead, rdRunState, "rdRunState", runWord(0, 0, 1, 0, 2'd0));
    snap = pulseCnt;
    writeFn(fnClrReset);
    expectEq("mrReset", 0, mrReset);
    readExpect(grpRead, rdRunState, "rdRunState", runWord(0, 0, 0, 0, 2'd0));
    readExpect(grpRead, rdConfig, "rdConfig", 6'h00);
    readExpect(grpRead, rdBurstHi, "rdBurstHi", 6'h00);
    readExpect(grpRead, rdBurstLo, "rdBurstLo", 6'h00);
    idleCycles(idleWait);
    // Request left from the held start may still land once
    if (pulseCnt - snap > 1) failRun("More than one EBOX clock after stop");

    // Random loads read back
    for (int k = 0; k < 3; k++) begin
      r = randWord();
      loadReg(ldBurstLo, {2'b00, r[3:0]});
      loadReg(ldBurstHi, {2'b00, r[7:4]});
      loadReg(ldRate, {4'b0000, r[9:8]});
      loadReg(ldDisable, {3'b000, r[12:10]});
      rateModel = r[9:8];
      disMask   = r[12:10];
      readExpect(grpRead, rdBurstHi, "rdBurstHi", {2'b00, r[7:4]});
      readExpect(grpRead, rdBurstLo, "rdBurstLo", {2'b00, r[3:0]});
      readExpect(grpRead, rdRunState, "rdRunState", runWord(0, 0, 0, 0, r[9:8]));
      readExpect(grpRead, rdConfig, "rdConfig", {r[12:10], 3'b000});
    end
    // Unused select and non-read group
    readExpect(grpRead, 3'd6, "unusedSel", 6'h00);
    readExpect(grpLoad, ldRate, "loadGroupRead", 6'h00);
    loadReg(ldDisable, 6'h00);
    disMask = 3'b000;

    // Burst of N and then a burst of zero
    @(posedge MBOX_CLK);
    cramTime <= ct3;
    loadReg(ldBurstLo, {2'b00, n3[3:0]});
    loadReg(ldBurstHi, 6'h00);
    base = pulseCnt;
    writeFn(fnBurst);
    waitPulses(base + n3);
    idleCycles(idleWait);
    expectEq("pulseCnt", base + n3, pulseCnt);
    readExpect(grpRead, rdBurstHi, "rdBurstHi", 6'h00);
    readExpect(grpRead, rdBurstLo, "rdBurstLo", 6'h00);
    writeFn(fnStop);
    base = pulseCnt;
    writeFn(fnBurst);
    idleCycles(idleWait);
    expectEq("pulseCnt", base, pulseCnt);
    writeFn(fnStop);

    // Single step and then free run and stop
    @(posedge MBOX_CLK);
    cramTime <= ct4;
    loadReg(ldRate, {4'b0000, rate4});
    rateModel = rate4;
    gapCheck  = 1'b1;
    base = pulseCnt;
    writeFn(fnSingleStep);
    waitPulses(base + 1);
    idleCycles(idleWait);
    expectEq("pulseCnt", base + 1, pulseCnt);
    base = pulseCnt;
    writeFn(fnStart);
    waitPulses(base + 5);
    writeFn(fnStop);
    snap = pulseCnt;
    idleCycles(idleWait);
    if (pulseCnt - snap > 1) failRun("More than one EBOX clock after stop");
    gapCheck = 1'b0;

    // Burst under a disable mask with an MBOX wait in the middle
    loadReg(ldDisable, {3'b000, mask5});
    disMask = mask5;
    @(posedge MBOX_CLK);
    cramTime <= ct5;
    loadReg(ldBurstLo, {2'b00, n5[3:0]});
    base = pulseCnt;
    snap = 0;
    for (int i = 0; i < 3; i++) grpCnt[i] = 0;
    writeFn(fnBurst);
    waitPulses(base + 1);
    @(posedge MBOX_CLK);
    mboxWait <= 1'b1;
    idleCycles(stall5);
    mboxWait <= 1'b0;
    waitPulses(base + n5);
    idleCycles(idleWait);
    expectEq("pulseCnt", base + n5, pulseCnt);
    for (int i = 0; i < 3; i++) begin
      expectEq($sformatf("clkEn[%0d] count", i), mask5[i] ? 0 : n5, grpCnt[i]);
    end
    writeFn(fnStop);
    loadReg(ldDisable, 6'h00);
    disMask = 3'b000;

    $display("*** PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

//--- build.f
clkPkg.sv
diagPort.sv
clockControlRegs.sv
burstCounter.sv
clockGate.sv
eboxSync.sv
klClock.sv
klClockTb.sv
